// ==== rtl/dma_defs.svh ====
// Width defines shared by the DMA package and RTL, pulled in with `include where needed
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Data word on the disk port and the memory bus
`define DMA_DATA_W 32

// Disk word address
`define DMA_DISK_AW 10

// Byte count, beat counter and disk word counter
`define DMA_CNT_W 16

`endif

// ==== rtl/dma_pkg.sv ====
// Job, data word and beat types passed between the DMA master stages
`default_nettype none

`include "dma_defs.svh"

package dma_pkg;

  // One data word, seen whole by the bus or as byte lanes by the aligner
  typedef union packed {
    logic [`DMA_DATA_W-1:0]        word;
    logic [`DMA_DATA_W/8-1:0][7:0] bytes;
  } dma_word_u;

  // Job geometry latched at start
  typedef struct packed {
    logic [`DMA_DATA_W-3:0]  mem_word_addr;
    logic [`DMA_DISK_AW-1:0] disk_addr;
    logic [1:0]              start_off;
    logic [1:0]              end_off;
    logic [`DMA_CNT_W-1:0]   num_beats;
    // Byte count over four, rounded up
    logic [`DMA_CNT_W-1:0]   num_words;
  } dma_job_t;

  // One memory write beat
  typedef struct packed {
    dma_word_u  data;
    logic [3:0] strb;
    logic       last;
  } dma_beat_t;

endpackage

`default_nettype wire

// ==== rtl/dma_setup.sv ====
// Start edge detect and job geometry for the DMA master, feeding reader, aligner and writer
`timescale 1ns/1ns
`default_nettype none

`include "dma_defs.svh"

module dma_setup (
  input  wire logic                    clk,
  input  wire logic                    arst_n_i,
  input  wire logic                    init_transfer_i,
  input  wire logic [`DMA_DISK_AW-1:0] disk_addr_i,
  input  wire logic [`DMA_DATA_W-1:0]  mem_addr_i,
  input  wire logic [`DMA_CNT_W-1:0]   transfer_size_i,
  input  wire logic                    job_end_i,
  output dma_pkg::dma_job_t            job_o,
  output logic                         job_go_o
);

  localparam int unsigned DW = `DMA_DATA_W;
  localparam int unsigned CW = `DMA_CNT_W;

  logic                    init_q;
  logic                    busy_q;
  logic                    start;
  logic [`DMA_DATA_W-1:0]  end_addr;
  logic [`DMA_CNT_W-1:0]   beat_sum;
  dma_pkg::dma_job_t       job_d;

  // Rising start level, dropped while a job runs
  assign start = init_transfer_i & ~init_q & ~busy_q;

  always_comb begin
    end_addr = mem_addr_i + DW'(transfer_size_i) - DW'(1);
    // Leading pad bytes count toward the beats
    beat_sum = transfer_size_i + CW'(mem_addr_i[1:0]);

    job_d.mem_word_addr = mem_addr_i[`DMA_DATA_W-1:2];
    job_d.disk_addr     = disk_addr_i;
    job_d.start_off     = mem_addr_i[1:0];
    job_d.end_off       = end_addr[1:0];
    job_d.num_beats     = (beat_sum >> 2) + CW'(|beat_sum[1:0]);
    job_d.num_words     = (transfer_size_i >> 2) + CW'(|transfer_size_i[1:0]);
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      init_q   <= 1'b0;
      busy_q   <= 1'b0;
      job_go_o <= 1'b0;
      job_o    <= '0;
    end else begin
      init_q   <= init_transfer_i;
      job_go_o <= start;
      if (start) begin
        job_o  <= job_d;
        busy_q <= 1'b1;
      end else if (job_end_i) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dma_disk_reader.sv ====
// Disk port requester of the DMA master, one word outstanding, stalled by the aligner hold
`timescale 1ns/1ns
`default_nettype none

`include "dma_defs.svh"

module dma_disk_reader (
  input  wire logic                    clk,
  input  wire logic                    arst_n_i,
  input  wire dma_pkg::dma_job_t       job_i,
  input  wire logic                    job_go_i,
  input  wire logic                    hold_i,
  output logic [`DMA_DISK_AW-1:0]      d_addr_o,
  output logic                         d_init_o,
  input  wire logic                    d_ready_i,
  input  wire logic [`DMA_DATA_W-1:0]  d_data_i,
  output logic                         d_done_o,
  output logic                         word_stb_o,
  output dma_pkg::dma_word_u           word_data_o
);

  localparam int unsigned AW = `DMA_DISK_AW;
  localparam int unsigned CW = `DMA_CNT_W;

  logic [`DMA_CNT_W-1:0] left_q;
  logic                  want_q;
  logic                  last_word;

  assign last_word = (left_q == CW'(1));

  // Done marks the reply to the final request
  assign d_done_o = d_ready_i & last_word;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      d_addr_o   <= '0;
      d_init_o   <= 1'b0;
      left_q     <= '0;
      want_q     <= 1'b0;
      word_stb_o <= 1'b0;
    end else begin
      d_init_o   <= 1'b0;
      word_stb_o <= d_ready_i;
      if (job_go_i) begin
        // Pipeline is empty at job start
        d_addr_o <= job_i.disk_addr;
        left_q   <= job_i.num_words;
        want_q   <= 1'b0;
        d_init_o <= (job_i.num_words != '0);
      end else if (d_ready_i) begin
        d_addr_o <= d_addr_o + AW'(1);
        left_q   <= left_q - CW'(1);
        if (!last_word) begin
          // Next request waits out the hold
          if (hold_i) begin
            want_q <= 1'b1;
          end else begin
            d_init_o <= 1'b1;
          end
        end
      end else if (want_q && !hold_i) begin
        want_q   <= 1'b0;
        d_init_o <= 1'b1;
      end
    end
  end

  // Disk data is only valid with d_ready
  always_ff @(posedge clk) begin
    if (d_ready_i) begin
      word_data_o.word <= d_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dma_byte_aligner.sv ====
// Byte aligner of the DMA master, turning disk words into strobed memory beats
`timescale 1ns/1ns
`default_nettype none

`include "dma_defs.svh"

module dma_byte_aligner (
  input  wire logic               clk,
  input  wire logic               arst_n_i,
  input  wire dma_pkg::dma_job_t  job_i,
  input  wire logic               job_go_i,
  input  wire logic               word_stb_i,
  input  wire dma_pkg::dma_word_u word_data_i,
  input  wire logic               wr_busy_i,
  output logic                    hold_o,
  output logic                    beat_stb_o,
  output dma_pkg::dma_beat_t      beat_o
);

  localparam int unsigned CW = `DMA_CNT_W;

  dma_pkg::dma_word_u    prev_q;
  dma_pkg::dma_word_u    cur_q;
  dma_pkg::dma_word_u    src_word;
  dma_pkg::dma_word_u    merged;
  logic                  pend_q;
  logic                  active_q;
  logic [`DMA_CNT_W-1:0] beat_idx_q;
  logic                  have_word;
  logic                  do_word;
  logic                  do_flush;
  logic                  emit;
  logic                  is_first;
  logic                  is_last;
  logic [3:0]            strb;
  logic [1:0]            lane_src;

  assign have_word = pend_q | word_stb_i;
  assign src_word  = pend_q ? cur_q : word_data_i;
  assign do_word   = have_word & ~wr_busy_i;

  // Leftover bytes of the last word form one more beat
  assign do_flush = active_q & ~have_word & ~wr_busy_i &
                    (beat_idx_q == job_i.num_words) &
                    (job_i.num_beats != job_i.num_words);
  assign emit     = do_word | do_flush;

  assign is_first = (beat_idx_q == '0);
  assign is_last  = (beat_idx_q == job_i.num_beats - CW'(1));

  // Reader waits until this stage and the writer are drained
  assign hold_o = pend_q | wr_busy_i;

  always_comb begin
    lane_src = '0;
    for (int l = 0; l < 4; l++) begin
      // Same byte index from either word, modulo four
      lane_src = 2'(l) - job_i.start_off;
      if (2'(l) < job_i.start_off) begin
        merged.bytes[l] = prev_q.bytes[lane_src];
      end else begin
        merged.bytes[l] = src_word.bytes[lane_src];
      end
      strb[l] = (~is_first | (2'(l) >= job_i.start_off)) &
                (~is_last | (2'(l) <= job_i.end_off));
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q     <= 1'b0;
      active_q   <= 1'b0;
      beat_idx_q <= '0;
      beat_stb_o <= 1'b0;
    end else begin
      beat_stb_o <= emit;
      if (job_go_i) begin
        active_q   <= 1'b1;
        beat_idx_q <= '0;
        pend_q     <= 1'b0;
      end else begin
        if (emit) begin
          beat_idx_q <= beat_idx_q + CW'(1);
          if (is_last) begin
            active_q <= 1'b0;
          end
        end
        // Park a word that lands while the writer is busy
        if (word_stb_i && wr_busy_i) begin
          pend_q <= 1'b1;
        end else if (do_word) begin
          pend_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (job_go_i) begin
      prev_q <= '0;
    end else if (do_word) begin
      prev_q <= src_word;
    end
    if (word_stb_i) begin
      cur_q <= word_data_i;
    end
    if (emit) begin
      beat_o.data <= merged;
      beat_o.strb <= strb;
      beat_o.last <= is_last;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dma_bus_writer.sv ====
// Memory bus writer of the DMA master, one cycle/ack write per beat plus the sticky interrupt
`timescale 1ns/1ns
`default_nettype none

`include "dma_defs.svh"

module dma_bus_writer (
  input  wire logic                   clk,
  input  wire logic                   arst_n_i,
  input  wire dma_pkg::dma_job_t      job_i,
  input  wire logic                   job_go_i,
  input  wire logic                   beat_stb_i,
  input  wire dma_pkg::dma_beat_t     beat_i,
  output logic                        wr_busy_o,
  output logic                        job_end_o,
  output logic                        m_cyc_o,
  output logic                        m_we_o,
  output logic [3:0]                  m_strb_o,
  output logic [`DMA_DATA_W-1:0]      m_addr_o,
  output logic [`DMA_DATA_W-1:0]      m_data_o,
  input  wire logic                   m_ack_i,
  output logic                        interrupt_o,
  input  wire logic                   int_clear_i
);

  localparam int unsigned WAW = `DMA_DATA_W - 2;

  logic [`DMA_DATA_W-3:0] addr_q;
  logic                   last_q;
  logic                   ack;
  dma_pkg::dma_word_u     data_q;

  assign ack = m_cyc_o & m_ack_i;

  // Busy from the incoming strobe through the whole cycle
  assign wr_busy_o = beat_stb_i | m_cyc_o;

  assign m_addr_o = {addr_q, 2'b00};
  assign m_data_o = data_q.word;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      m_cyc_o     <= 1'b0;
      m_we_o      <= 1'b0;
      m_strb_o    <= '0;
      addr_q      <= '0;
      last_q      <= 1'b0;
      job_end_o   <= 1'b0;
      interrupt_o <= 1'b0;
    end else begin
      job_end_o <= 1'b0;
      if (job_go_i) begin
        addr_q <= job_i.mem_word_addr;
      end
      if (beat_stb_i) begin
        m_cyc_o  <= 1'b1;
        m_we_o   <= 1'b1;
        m_strb_o <= beat_i.strb;
        last_q   <= beat_i.last;
      end else if (ack) begin
        // Cycle ends the clock after its ack
        m_cyc_o  <= 1'b0;
        m_we_o   <= 1'b0;
        m_strb_o <= '0;
        addr_q   <= addr_q + WAW'(1);
        if (last_q) begin
          job_end_o <= 1'b1;
        end
      end

      // Sticky until software clears it
      if (ack && last_q) begin
        interrupt_o <= 1'b1;
      end else if (int_clear_i) begin
        interrupt_o <= 1'b0;
      end
    end
  end

  // Write data of the current beat
  always_ff @(posedge clk) begin
    if (beat_stb_i) begin
      data_q <= beat_i.data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dma_master_if.sv ====
// Top level of the DMA master, chaining setup, disk reader, byte aligner and bus writer
`timescale 1ns/1ns
`default_nettype none

`include "dma_defs.svh"

module dma_master_if (
  input  wire logic                    clk,
  input  wire logic                    arst_n_i,
  // Job programming
  input  wire logic [`DMA_DISK_AW-1:0] disk_addr_i,
  input  wire logic [`DMA_DATA_W-1:0]  mem_addr_i,
  input  wire logic [`DMA_CNT_W-1:0]   transfer_size_i,
  input  wire logic                    init_transfer_i,
  // Disk port
  output logic [`DMA_DISK_AW-1:0]      d_addr_o,
  output logic                         d_init_o,
  input  wire logic                    d_ready_i,
  input  wire logic [`DMA_DATA_W-1:0]  d_data_i,
  output logic                         d_done_o,
  // Memory bus
  output logic                         m_cyc_o,
  output logic                         m_we_o,
  output logic [3:0]                   m_strb_o,
  output logic [`DMA_DATA_W-1:0]       m_addr_o,
  output logic [`DMA_DATA_W-1:0]       m_data_o,
  input  wire logic                    m_ack_i,
  // Interrupt
  output logic                         interrupt_o,
  input  wire logic                    int_clear_i
);

  dma_pkg::dma_job_t  job;
  logic               job_go;
  logic               job_end;
  logic               word_stb;
  dma_pkg::dma_word_u word_data;
  logic               hold;
  logic               beat_stb;
  dma_pkg::dma_beat_t beat;
  logic               wr_busy;

  dma_setup u_setup (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .init_transfer_i (init_transfer_i),
    .disk_addr_i     (disk_addr_i),
    .mem_addr_i      (mem_addr_i),
    .transfer_size_i (transfer_size_i),
    .job_end_i       (job_end),
    .job_o           (job),
    .job_go_o        (job_go)
  );

  dma_disk_reader u_reader (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .job_i       (job),
    .job_go_i    (job_go),
    .hold_i      (hold),
    .d_addr_o    (d_addr_o),
    .d_init_o    (d_init_o),
    .d_ready_i   (d_ready_i),
    .d_data_i    (d_data_i),
    .d_done_o    (d_done_o),
    .word_stb_o  (word_stb),
    .word_data_o (word_data)
  );

  // Hold folds in the writer busy level
  dma_byte_aligner u_aligner (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .job_i       (job),
    .job_go_i    (job_go),
    .word_stb_i  (word_stb),
    .word_data_i (word_data),
    .wr_busy_i   (wr_busy),
    .hold_o      (hold),
    .beat_stb_o  (beat_stb),
    .beat_o      (beat)
  );

  dma_bus_writer u_writer (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .job_i       (job),
    .job_go_i    (job_go),
    .beat_stb_i  (beat_stb),
    .beat_i      (beat),
    .wr_busy_o   (wr_busy),
    .job_end_o   (job_end),
    .m_cyc_o     (m_cyc_o),
    .m_we_o      (m_we_o),
    .m_strb_o    (m_strb_o),
    .m_addr_o    (m_addr_o),
    .m_data_o    (m_data_o),
    .m_ack_i     (m_ack_i),
    .interrupt_o (interrupt_o),
    .int_clear_i (int_clear_i)
  );

endmodule

`default_nettype wire

// ==== sim/dma_sva.sv ====
// Protocol checks on the disk port and memory bus of the DMA master, attached to it with bind
`timescale 1ns/1ns
`default_nettype none

`include "dma_defs.svh"

module dma_sva (
  input wire logic                   clk,
  input wire logic                   arst_n_i,
  input wire logic                   d_init_o,
  input wire logic                   d_ready_i,
  input wire logic                   d_done_o,
  input wire logic                   m_cyc_o,
  input wire logic                   m_we_o,
  input wire logic [3:0]             m_strb_o,
  input wire logic [`DMA_DATA_W-1:0] m_addr_o,
  input wire logic [`DMA_DATA_W-1:0] m_data_o,
  input wire logic                   m_ack_i,
  input wire logic                   interrupt_o
);

  // Disk request waiting for its reply
  logic req_open;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_open <= 1'b0;
    end else if (d_init_o) begin
      req_open <= 1'b1;
    end else if (d_ready_i) begin
      req_open <= 1'b0;
    end
  end

  reset_quiet: assert property (@(posedge clk) !arst_n_i |->
    (!d_init_o && !d_done_o && !m_cyc_o && !m_we_o && m_strb_o == 4'h0 && !interrupt_o))
    else $error("DMA outputs active while reset is held");

  // One request outstanding on the disk port
  single_request: assert property (@(posedge clk) disable iff (!arst_n_i)
    d_init_o |-> !req_open)
    else $error("second disk request before the reply");

  reply_expected: assert property (@(posedge clk) disable iff (!arst_n_i)
    d_ready_i |-> req_open)
    else $error("disk reply without a request");

  done_with_reply: assert property (@(posedge clk) disable iff (!arst_n_i)
    d_done_o |-> d_ready_i)
    else $error("disk done without a reply");

  write_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
    m_cyc_o |-> m_we_o)
    else $error("bus cycle is not a write");

  // Bus fields frozen until the ack
  bus_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    (m_cyc_o && !m_ack_i) |=> (m_cyc_o && $stable(m_strb_o) && $stable(m_addr_o) &&
                               $stable(m_data_o)))
    else $error("bus fields changed before the ack");

  bus_release: assert property (@(posedge clk) disable iff (!arst_n_i)
    (m_cyc_o && m_ack_i) |=> !m_cyc_o)
    else $error("bus cycle still open after its ack");

endmodule

`default_nettype wire

// ==== sim/dma_tb.sv ====
// Testbench for the DMA master, with disk and memory models, random jobs and checks by assertion
`timescale 1ns/1ns
`default_nettype none

`include "dma_defs.svh"

module dma_tb;

  localparam int MEM_BYTES  = 1024;
  localparam int DISK_WORDS = 1 << `DMA_DISK_AW;
  localparam int WAIT_LIMIT = 600;

  logic                    clk = 1'b0;
  logic                    arst_n_i;
  logic [`DMA_DISK_AW-1:0] disk_addr_i;
  logic [`DMA_DATA_W-1:0]  mem_addr_i;
  logic [`DMA_CNT_W-1:0]   transfer_size_i;
  logic                    init_transfer_i;
  logic [`DMA_DISK_AW-1:0] d_addr_o;
  logic                    d_init_o;
  logic                    d_ready_i;
  logic [`DMA_DATA_W-1:0]  d_data_i;
  logic                    d_done_o;
  logic                    m_cyc_o;
  logic                    m_we_o;
  logic [3:0]              m_strb_o;
  logic [`DMA_DATA_W-1:0]  m_addr_o;
  logic [`DMA_DATA_W-1:0]  m_data_o;
  logic                    m_ack_i;
  logic                    interrupt_o;
  logic                    int_clear_i;

  logic [31:0]             disk_img [DISK_WORDS];
  logic [7:0]              mem_img [MEM_BYTES];
  logic [31:0]             rng_main;
  logic [31:0]             rng_disk;
  logic [31:0]             rng_bus;
  logic                    disk_pend;
  int                      disk_wait;
  logic [`DMA_DISK_AW-1:0] disk_req_addr;
  logic                    bus_active;
  int                      bus_wait;
  int                      ack_count;
  int                      init_count;
  int                      mem_tag;
  // Expectations of the running job
  int                      job_tag;
  int                      exp_beats;
  int                      exp_words;
  int                      ack_base;
  int                      init_base;
  logic                    aligned_job;

  always #5 clk = ~clk;

  dma_master_if UUT (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .disk_addr_i     (disk_addr_i),
    .mem_addr_i      (mem_addr_i),
    .transfer_size_i (transfer_size_i),
    .init_transfer_i (init_transfer_i),
    .d_addr_o        (d_addr_o),
    .d_init_o        (d_init_o),
    .d_ready_i       (d_ready_i),
    .d_data_i        (d_data_i),
    .d_done_o        (d_done_o),
    .m_cyc_o         (m_cyc_o),
    .m_we_o          (m_we_o),
    .m_strb_o        (m_strb_o),
    .m_addr_o        (m_addr_o),
    .m_data_o        (m_data_o),
    .m_ack_i         (m_ack_i),
    .interrupt_o     (interrupt_o),
    .int_clear_i     (int_clear_i)
  );

  bind dma_master_if dma_sva u_sva (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .d_init_o    (d_init_o),
    .d_ready_i   (d_ready_i),
    .d_done_o    (d_done_o),
    .m_cyc_o     (m_cyc_o),
    .m_we_o      (m_we_o),
    .m_strb_o    (m_strb_o),
    .m_addr_o    (m_addr_o),
    .m_data_o    (m_data_o),
    .m_ack_i     (m_ack_i),
    .interrupt_o (interrupt_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Background byte, new for every job
  function automatic logic [7:0] fill_byte(input int addr, input int tag);
    return 8'(addr ^ (addr >> 8) ^ (tag * 37) ^ 92);
  endfunction

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic apply_reset();
    arst_n_i = 1'b0;
    repeat (8) @(negedge clk);
    arst_n_i = 1'b1;
  endtask

  task automatic check_idle();
    assert (!d_init_o && !d_done_o && !m_cyc_o && !m_we_o && m_strb_o == 4'h0 && !interrupt_o)
      else stop_with_failure($sformatf("mismatch at %0t: outputs not idle after reset", $time));
  endtask

  // Disk bytes in range, background elsewhere
  task automatic check_memory(input logic [9:0] daddr, input int maddr, input int size,
                              input int tag);
    logic [7:0] exp_b;
    logic [9:0] widx;
    for (int a = 0; a < MEM_BYTES; a++) begin
      if (a >= maddr && a < maddr + size) begin
        widx  = daddr + 10'((a - maddr) / 4);
        exp_b = disk_img[widx][8*((a - maddr) % 4) +: 8];
      end else begin
        exp_b = fill_byte(a, tag);
      end
      assert (mem_img[a] == exp_b) else stop_with_failure($sformatf(
        "mismatch at %0t: memory byte %0d is %h, expected %h", $time, a, mem_img[a], exp_b));
    end
  endtask

  task automatic run_job(input int tag, input logic [9:0] daddr, input int maddr,
                         input int size, input logic clear_irq);
    int cycles;
    @(negedge clk);
    job_tag         = tag;
    exp_beats       = (size + maddr % 4 + 3) / 4;
    exp_words       = (size + 3) / 4;
    ack_base        = ack_count;
    init_base       = init_count;
    aligned_job     = (maddr % 4 == 0) && (size % 4 == 0);
    disk_addr_i     = daddr;
    mem_addr_i      = 32'(maddr);
    transfer_size_i = 16'(size);
    init_transfer_i = 1'b1;
    repeat (2) @(negedge clk);
    init_transfer_i = 1'b0;
    // Raised again while busy, must not start a second job
    repeat (2) @(negedge clk);
    init_transfer_i = 1'b1;
    cycles = 0;
    while (!interrupt_o && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!interrupt_o) begin
      stop_with_failure($sformatf("no interrupt from job %0d within %0d cycles", tag, cycles));
    end
    repeat (3) @(negedge clk);
    init_transfer_i = 1'b0;
    assert (interrupt_o)
      else stop_with_failure($sformatf("mismatch at %0t: interrupt did not stay set", $time));
    assert (ack_count - ack_base == exp_beats) else stop_with_failure($sformatf(
      "mismatch at %0t: %0d acks, expected %0d", $time, ack_count - ack_base, exp_beats));
    assert (init_count - init_base == exp_words) else stop_with_failure($sformatf(
      "mismatch at %0t: %0d disk requests, expected %0d", $time, init_count - init_base,
      exp_words));
    check_memory(daddr, maddr, size, tag);
    if (clear_irq) begin
      int_clear_i = 1'b1;
      @(negedge clk);
      int_clear_i = 1'b0;
      assert (!interrupt_o)
        else stop_with_failure($sformatf("mismatch at %0t: interrupt kept after clear", $time));
    end
  endtask

  assert property (@(posedge clk) disable iff (!arst_n_i)
    $rose(interrupt_o) |-> (ack_count - ack_base == exp_beats))
    else stop_with_failure($sformatf("mismatch at %0t: interrupt after %0d of %0d acks",
      $time, ack_count - ack_base, exp_beats));

  assert property (@(posedge clk) disable iff (!arst_n_i)
    $fell(interrupt_o) |-> $past(int_clear_i))
    else stop_with_failure($sformatf("mismatch at %0t: interrupt fell without clear", $time));

  // Done comes with the reply to the last request and with no other
  assert property (@(posedge clk) disable iff (!arst_n_i)
    d_done_o == (d_ready_i && (init_count - init_base == exp_words)))
    else stop_with_failure($sformatf("mismatch at %0t: disk done wrong after %0d of %0d requests",
      $time, init_count - init_base, exp_words));

  // Disk and memory models, both answering on the falling edge
  initial begin
    d_ready_i  = 1'b0;
    d_data_i   = '0;
    m_ack_i    = 1'b0;
    disk_pend  = 1'b0;
    bus_active = 1'b0;
    disk_wait  = 0;
    bus_wait   = 0;
    ack_count  = 0;
    init_count = 0;
    mem_tag    = -1;
    rng_disk   = lcg_next(32'h9310);
    rng_bus    = lcg_next(rng_disk);
    forever begin
      @(negedge clk);
      d_ready_i = 1'b0;
      m_ack_i   = 1'b0;
      if (mem_tag != job_tag) begin
        for (int a = 0; a < MEM_BYTES; a++) begin
          mem_img[a] = fill_byte(a, job_tag);
        end
        mem_tag = job_tag;
      end
      if (!arst_n_i) begin
        disk_pend  = 1'b0;
        bus_active = 1'b0;
      end else begin
        if (disk_pend) begin
          if (disk_wait == 0) begin
            d_ready_i = 1'b1;
            d_data_i  = disk_img[disk_req_addr];
            disk_pend = 1'b0;
          end else begin
            disk_wait--;
          end
        end
        if (d_init_o) begin
          rng_disk      = lcg_next(rng_disk);
          disk_wait     = int'(rng_disk[18:17]);
          disk_req_addr = d_addr_o;
          disk_pend     = 1'b1;
          init_count++;
        end
        if (m_cyc_o) begin
          if (!bus_active) begin
            rng_bus    = lcg_next(rng_bus);
            bus_wait   = int'(rng_bus[19:18]);
            bus_active = 1'b1;
          end
          if (bus_wait == 0) begin
            assert (!aligned_job || m_strb_o == 4'hf) else stop_with_failure($sformatf(
              "mismatch at %0t: strobe %h in aligned job", $time, m_strb_o));
            for (int l = 0; l < 4; l++) begin
              if (m_strb_o[l]) begin
                mem_img[m_addr_o[9:0] + 10'(l)] = m_data_o[8*l +: 8];
              end
            end
            m_ack_i    = 1'b1;
            bus_active = 1'b0;
            ack_count++;
          end else begin
            bus_wait--;
          end
        end
      end
    end
  end

  initial begin
    int maddr;
    int size;
    init_transfer_i = 1'b0;
    int_clear_i     = 1'b0;
    disk_addr_i     = '0;
    mem_addr_i      = '0;
    transfer_size_i = '0;
    job_tag         = 0;
    exp_beats       = 0;
    exp_words       = 0;
    ack_base        = 0;
    init_base       = 0;
    aligned_job     = 1'b0;
    rng_main        = 32'h9310;
    for (int w = 0; w < DISK_WORDS; w++) begin
      rng_main    = lcg_next(rng_main);
      disk_img[w] = rng_main;
    end
    apply_reset();
    check_idle();

    // Word aligned start and size
    rng_main = lcg_next(rng_main);
    run_job(1, rng_main[25:16], 4 * (int'(rng_main[31:24]) % 200),
            4 * (int'(rng_main[15:12]) % 10 + 1), 1'b1);
    // Disk address wrap, single beat, flush beat
    run_job(2, 10'h3ff, 'h101, 9, 1'b1);
    run_job(3, 10'h010, 'h102, 2, 1'b1);
    run_job(4, 10'h020, 'h031, 4, 1'b1);
    for (int j = 5; j < 17; j++) begin
      rng_main = lcg_next(rng_main);
      maddr    = int'(rng_main[31:16]) % 900;
      rng_main = lcg_next(rng_main);
      size     = int'(rng_main[31:16]) % 48 + 1;
      run_job(j, rng_main[13:4], maddr, size, 1'b1);
    end

    // Interrupt left set, then cleared by reset
    run_job(17, 10'h155, 'h0f3, 21, 1'b0);
    apply_reset();
    check_idle();
    repeat (3) @(negedge clk);
    check_idle();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+rtl
rtl/dma_pkg.sv
rtl/dma_setup.sv
rtl/dma_disk_reader.sv
rtl/dma_byte_aligner.sv
rtl/dma_bus_writer.sv
rtl/dma_master_if.sv
sim/dma_sva.sv
sim/dma_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the DMA master testbench with Verilator and runs it, exit status gives the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module dma_tb -f flist.f -o dma_sim &&
./obj_dir/dma_sim || exit 1
